//--- list.f
+incdir+.
lc3b_isa_pkg.sv
lc3b_pipe_pkg.sv
byte_lane_logic.sv
branch_resolve.sv
mem_stall_logic.sv
mem_stage.sv
dcache_model.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_mem_subsystem
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_params.svh"

module tb_mem_subsystem;

	typedef struct packed {
		lc3b_isa_pkg::lc3b_opcode opcode;
		lc3b_isa_pkg::lc3b_word address;
		lc3b_isa_pkg::lc3b_word result;
		lc3b_isa_pkg::lc3b_word ir;
		lc3b_isa_pkg::lc3b_reg dr;
		lc3b_isa_pkg::lc3b_nzp cc;
		logic valid;
		lc3b_isa_pkg::lc3b_word exp_ptr;    // Pointer that LDI and STI must find.
		logic rand_data;
		logic [3:0] icache_hold;
	} row_t;

	logic clk;
	logic rst_n;
	lc3b_pipe_pkg::ex_mem_latch_t ex_mem;
	logic icache_stall;
	lc3b_pipe_pkg::mem_wb_latch_t mem_wb;
	lc3b_pipe_pkg::pc_src_t pc_src;
	logic mem_stall;
	logic mem_br_stall;
	logic load_wb;
	logic mem_load_cc;
	logic mem_load_regfile;

	row_t rows[$];
	lc3b_isa_pkg::lc3b_word shadow [`LC3B_DMEM_WORDS];
	logic [31:0] rng;
	int limit_ns;

	mem_subsystem_top i_mem_subsystem_top (
		.clk(clk),
		.rst_n(rst_n),
		.ex_mem(ex_mem),
		.icache_stall(icache_stall),
		.mem_wb(mem_wb),
		.pc_src(pc_src),
		.mem_stall(mem_stall),
		.mem_br_stall(mem_br_stall),
		.load_wb(load_wb),
		.mem_load_cc(mem_load_cc),
		.mem_load_regfile(mem_load_regfile)
	);

	always #10 clk = ~clk;

	// --------------------------------------------------
	// Failure reporting and compare tasks
	// --------------------------------------------------
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input lc3b_isa_pkg::lc3b_word got,
		input lc3b_isa_pkg::lc3b_word exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_reg(input string name, input lc3b_isa_pkg::lc3b_reg got,
		input lc3b_isa_pkg::lc3b_reg exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_pc(input string name, input lc3b_pipe_pkg::pc_src_t got,
		input lc3b_pipe_pkg::pc_src_t exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_cw(input string name, input lc3b_pipe_pkg::lc3b_control_word got,
		input lc3b_pipe_pkg::lc3b_control_word exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	// --------------------------------------------------
	// Reference rules
	// --------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic int word_index(input lc3b_isa_pkg::lc3b_word addr);
		return int'(addr[15:1]) % `LC3B_DMEM_WORDS;
	endfunction

	// Control word as the decode stage would build it.
	function automatic lc3b_pipe_pkg::lc3b_control_word decode(
		input lc3b_isa_pkg::lc3b_opcode op);
		lc3b_pipe_pkg::lc3b_control_word cw;
		cw = '0;
		cw.opcode = op;
		case (op)
			lc3b_isa_pkg::op_ldr, lc3b_isa_pkg::op_ldi, lc3b_isa_pkg::op_ldb: begin
				cw.mem_read = 1'b1;
				cw.load_cc = 1'b1;
				cw.load_regfile = 1'b1;
				cw.byte_op = (op == lc3b_isa_pkg::op_ldb);
			end
			lc3b_isa_pkg::op_str, lc3b_isa_pkg::op_sti, lc3b_isa_pkg::op_stb: begin
				cw.mem_write = 1'b1;
				cw.byte_op = (op == lc3b_isa_pkg::op_stb);
			end
			lc3b_isa_pkg::op_trap: begin
				cw.mem_read = 1'b1;
				cw.load_regfile = 1'b1;    // R7 takes the return PC.
				cw.branch_stall = 1'b1;
			end
			lc3b_isa_pkg::op_br, lc3b_isa_pkg::op_jmp: cw.branch_stall = 1'b1;
			lc3b_isa_pkg::op_jsr: begin
				cw.branch_stall = 1'b1;
				cw.load_regfile = 1'b1;
			end
			default: begin
				cw.load_cc = 1'b1;
				cw.load_regfile = 1'b1;
			end
		endcase
		return cw;
	endfunction

	function automatic lc3b_pipe_pkg::pc_src_t expected_pc_src(input row_t r);
		if (!r.valid)
			return lc3b_pipe_pkg::pc_seq;
		case (r.opcode)
			lc3b_isa_pkg::op_jmp, lc3b_isa_pkg::op_jsr: return lc3b_pipe_pkg::pc_target;
			lc3b_isa_pkg::op_trap: return lc3b_pipe_pkg::pc_mem_data;
			lc3b_isa_pkg::op_br:
				return ((r.cc & r.ir[11:9]) != 3'b000) ? lc3b_pipe_pkg::pc_target
					: lc3b_pipe_pkg::pc_seq;
			default: return lc3b_pipe_pkg::pc_seq;
		endcase
	endfunction

	task automatic add_row(input lc3b_isa_pkg::lc3b_opcode op, input logic [15:0] addr,
		input logic [15:0] result, input logic [15:0] ir, input logic [2:0] dr,
		input logic [2:0] cc, input logic valid, input logic [15:0] exp_ptr,
		input logic rand_data, input logic [3:0] hold);
		row_t r;
		r = '{op, addr, result, ir, dr, cc, valid, exp_ptr, rand_data, hold};
		rows.push_back(r);
	endtask

	// --------------------------------------------------
	// One row: drive, wait for the stall to drop, check
	// --------------------------------------------------
	task automatic apply_row(input row_t r);
		lc3b_pipe_pkg::lc3b_control_word cw;
		lc3b_isa_pkg::lc3b_word data;
		lc3b_isa_pkg::lc3b_word ptr;
		lc3b_isa_pkg::lc3b_word exp_data;
		lc3b_isa_pkg::lc3b_word new_pc;
		lc3b_isa_pkg::lc3b_byte b;
		logic is_access;
		logic is_ind;
		int exp_stall;
		int n_stall;
		cw = decode(r.opcode);
		data = r.result;
		if (r.rand_data) begin
			rng = xorshift32(rng);
			data = rng[15:0];
		end
		new_pc = r.address + 16'h0002;
		is_access = r.valid && (cw.mem_read || cw.mem_write);
		is_ind = (r.opcode == lc3b_isa_pkg::op_ldi) || (r.opcode == lc3b_isa_pkg::op_sti);
		exp_stall = !is_access ? 0 : (is_ind ? 2 * `LC3B_DCACHE_LAT + 1 : `LC3B_DCACHE_LAT);
		ptr = shadow[word_index(r.address)];
		if (is_access && is_ind && (ptr !== r.exp_ptr))
			fail_run("The pointer in the shadow memory differs from the table entry.");

		ex_mem.valid = r.valid;
		ex_mem.cw = cw;
		ex_mem.address = r.address;
		ex_mem.new_pc = new_pc;
		ex_mem.result = data;
		ex_mem.ir = r.ir;
		ex_mem.dr = r.dr;
		ex_mem.cc = r.cc;
		icache_stall = (r.icache_hold != 4'd0);

		n_stall = 0;
		@(negedge clk);
		while (mem_stall) begin
			n_stall++;
			@(negedge clk);
		end

		check_word("stall cycles", lc3b_isa_pkg::lc3b_word'(n_stall),
			lc3b_isa_pkg::lc3b_word'(exp_stall));
		check_bit("mem_wb.valid", mem_wb.valid, r.valid);
		check_cw("mem_wb.cw", mem_wb.cw, cw);
		check_reg("mem_wb.dr", mem_wb.dr, r.dr);
		check_word("mem_wb.result", mem_wb.result, data);
		check_word("mem_wb.new_pc", mem_wb.new_pc, new_pc);
		check_word("mem_wb.ir", mem_wb.ir, r.ir);
		check_pc("pc_src", pc_src, expected_pc_src(r));
		check_bit("mem_load_cc", mem_load_cc, r.valid && cw.load_cc);
		check_bit("mem_load_regfile", mem_load_regfile, r.valid && cw.load_regfile);
		check_bit("mem_br_stall", mem_br_stall, r.valid && cw.branch_stall);
		check_bit("load_wb", load_wb, r.valid && (r.icache_hold == 4'd0));

		if (is_access && cw.mem_read) begin
			exp_data = is_ind ? shadow[word_index(ptr)] : shadow[word_index(r.address)];
			if (cw.byte_op) begin
				b = r.address[0] ? exp_data[15:8] : exp_data[7:0];
				exp_data = {{8{b[7]}}, b};
			end
			if ($isunknown(exp_data))
				fail_run("A table row reads a location that was never written.");
			check_word("mem_wb.data", mem_wb.data, exp_data);
		end

		// The finished instruction waits in the FSM while the instruction cache stalls.
		if (r.icache_hold != 4'd0) begin
			repeat (r.icache_hold) begin
				@(negedge clk);
				check_bit("load_wb", load_wb, 1'b0);
				check_bit("mem_stall", mem_stall, 1'b0);
			end
			@(posedge clk);
			#2;
			icache_stall = 1'b0;
			@(negedge clk);
			check_bit("load_wb", load_wb, r.valid);
		end

		if (is_access && cw.mem_write) begin
			if (r.opcode == lc3b_isa_pkg::op_stb) begin
				if (r.address[0])
					shadow[word_index(r.address)][15:8] = data[7:0];
				else
					shadow[word_index(r.address)][7:0] = data[7:0];
			end else if (is_ind) begin
				shadow[word_index(ptr)] = data;
			end else begin
				shadow[word_index(r.address)] = data;
			end
		end

		@(posedge clk);
		#2;
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		ex_mem = '0;
		icache_stall = 1'b0;
		rng = 32'd50052;
		foreach (shadow[i])
			shadow[i] = 'x;

		// op, address, result, ir, dr, cc, valid, pointer, random, icache hold
		add_row(lc3b_isa_pkg::op_str, 16'h0100, 16'h0000, 16'h7000, 3'd1, 3'b000, 1, 16'h0, 1, 0);
		add_row(lc3b_isa_pkg::op_ldr, 16'h0100, 16'h0000, 16'h6400, 3'd2, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_str, 16'h0200, 16'h1234, 16'h7000, 3'd1, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_stb, 16'h0200, 16'h0085, 16'h3000, 3'd1, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_stb, 16'h0201, 16'hAB3C, 16'h3000, 3'd1, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_ldb, 16'h0200, 16'h0000, 16'h2000, 3'd3, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_ldb, 16'h0201, 16'h0000, 16'h2000, 3'd4, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_ldr, 16'h0200, 16'h0000, 16'h6000, 3'd2, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_str, 16'h0300, 16'h0400, 16'h7000, 3'd1, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_str, 16'h0400, 16'h0000, 16'h7000, 3'd1, 3'b000, 1, 16'h0, 1, 0);
		add_row(lc3b_isa_pkg::op_sti, 16'h0300, 16'h0000, 16'hB000, 3'd1, 3'b000, 1, 16'h0400, 1, 0);
		add_row(lc3b_isa_pkg::op_ldi, 16'h0300, 16'h0000, 16'hA000, 3'd5, 3'b000, 1, 16'h0400, 0, 0);
		add_row(lc3b_isa_pkg::op_ldr, 16'h0400, 16'h0000, 16'h6000, 3'd6, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_str, 16'h0020, 16'h3000, 16'h7000, 3'd1, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_br, 16'h0050, 16'h0000, 16'h0A00, 3'd0, 3'b001, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_br, 16'h0050, 16'h0000, 16'h0800, 3'd0, 3'b010, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_jmp, 16'h0060, 16'h0000, 16'hC1C0, 3'd0, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_jsr, 16'h0070, 16'h0000, 16'h4800, 3'd7, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_trap, 16'h0020, 16'h0000, 16'hF010, 3'd7, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_str, 16'h0100, 16'hDEAD, 16'h7000, 3'd1, 3'b000, 0, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_ldr, 16'h0100, 16'h0000, 16'h6000, 3'd2, 3'b000, 1, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_add, 16'h0000, 16'h0042, 16'h1000, 3'd3, 3'b000, 0, 16'h0, 0, 0);
		add_row(lc3b_isa_pkg::op_ldr, 16'h0200, 16'h0000, 16'h6000, 3'd4, 3'b000, 1, 16'h0, 0, 4);
		add_row(lc3b_isa_pkg::op_add, 16'h0000, 16'h0042, 16'h1000, 3'd3, 3'b000, 1, 16'h0, 0, 0);

		limit_ns = (rows.size() + 1) * (2 * `LC3B_DCACHE_LAT + 6) * 20;
		fork
			begin
				#(limit_ns * 1ns);
				fail_run("Watchdog expired before all table rows completed.");
			end
		join_none

		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		check_bit("mem_stall", mem_stall, 1'b0);
		check_bit("load_wb", load_wb, 1'b0);
		@(posedge clk);
		#2;

		foreach (rows[i])
			apply_row(rows[i]);

		ex_mem = '0;
		$display("sim passed");
		$finish;
	end

endmodule : tb_mem_subsystem

`default_nettype wire

//--- mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire lc3b_pipe_pkg::ex_mem_latch_t ex_mem,
	input  wire logic icache_stall,
	output lc3b_pipe_pkg::mem_wb_latch_t mem_wb,
	output lc3b_pipe_pkg::pc_src_t pc_src,
	output logic mem_stall,
	output logic mem_br_stall,
	output logic load_wb,
	output logic mem_load_cc,
	output logic mem_load_regfile
);

	lc3b_pipe_pkg::dcache_req_t dcache_req;
	lc3b_isa_pkg::lc3b_word dcache_rdata;
	logic dcache_resp;

	mem_stage i_mem_stage (
		.clk(clk),
		.rst_n(rst_n),
		.ex_mem(ex_mem),
		.icache_stall(icache_stall),
		.rdata(dcache_rdata),
		.resp(dcache_resp),
		.dcache_req(dcache_req),
		.mem_wb(mem_wb),
		.pc_src(pc_src),
		.mem_stall(mem_stall),
		.mem_br_stall(mem_br_stall),
		.load_wb(load_wb),
		.mem_load_cc(mem_load_cc),
		.mem_load_regfile(mem_load_regfile)
	);

	dcache_model i_dcache_model (
		.clk(clk),
		.rst_n(rst_n),
		.req(dcache_req),
		.rdata(dcache_rdata),
		.resp(dcache_resp)
	);

endmodule : mem_subsystem_top

`default_nettype wire

//--- dcache_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_params.svh"

module dcache_model (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire lc3b_pipe_pkg::dcache_req_t req,
	output lc3b_isa_pkg::lc3b_word rdata,
	output logic resp
);

	typedef logic [$clog2(`LC3B_DCACHE_LAT+1)-1:0] lat_cnt_t;
	typedef logic [$clog2(`LC3B_DMEM_WORDS)-1:0] word_idx_t;

	lc3b_isa_pkg::lc3b_word mem [`LC3B_DMEM_WORDS];
	word_idx_t word_idx;
	lat_cnt_t cnt;
	logic busy;
	logic req_on;

	assign req_on = req.read || req.write;
	assign word_idx = req.address[$clog2(`LC3B_DMEM_WORDS):1];    // Bit 0 picks the byte.

	// --------------------------------------------------
	// Latency counter
	// --------------------------------------------------
	// A request seen while not busy starts a fresh count.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (resp) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (busy) begin
			cnt <= cnt + lat_cnt_t'(1);
		end else if (req_on) begin
			busy <= 1'b1;
			cnt <= lat_cnt_t'(1);
		end
	end

	assign resp = busy && (cnt == lat_cnt_t'(`LC3B_DCACHE_LAT));

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (resp && req.write) begin
			if (req.byte_enable[0])
				mem[word_idx][7:0] <= req.wdata[7:0];
			if (req.byte_enable[1])
				mem[word_idx][15:8] <= req.wdata[15:8];
		end
	end

	assign rdata = mem[word_idx];

	// The lanes come from the stage's byte logic.
	assert property (@(posedge clk) disable iff (!rst_n)
		req.write |-> (req.byte_enable != 2'b00))
		else $error("dcache_model: write with no byte enabled");

endmodule : dcache_model

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire lc3b_pipe_pkg::ex_mem_latch_t ex_mem,
	input  wire logic icache_stall,
	input  wire lc3b_isa_pkg::lc3b_word rdata,
	input  wire logic resp,
	output lc3b_pipe_pkg::dcache_req_t dcache_req,
	output lc3b_pipe_pkg::mem_wb_latch_t mem_wb,
	output lc3b_pipe_pkg::pc_src_t pc_src,
	output logic mem_stall,
	output logic mem_br_stall,
	output logic load_wb,
	output logic mem_load_cc,
	output logic mem_load_regfile
);

	logic indirect;
	logic access;
	logic req_on;
	logic ptr_phase;
	logic second_phase;
	logic ptr_load;
	logic fsm_load_wb;
	logic [1:0] byte_enable;
	lc3b_isa_pkg::lc3b_word ptr_q;
	lc3b_isa_pkg::lc3b_word mem_addr;
	lc3b_isa_pkg::lc3b_word word_in;
	lc3b_isa_pkg::lc3b_word load_data;

	// --------------------------------------------------
	// Access decode
	// --------------------------------------------------
	assign indirect = (ex_mem.cw.opcode == lc3b_isa_pkg::op_ldi) ||
		(ex_mem.cw.opcode == lc3b_isa_pkg::op_sti);
	assign access = ex_mem.valid && (ex_mem.cw.mem_read || ex_mem.cw.mem_write);

	// The request is held from the first stalled cycle through the last response.
	assign req_on = access && (mem_stall || second_phase);
	assign ptr_phase = indirect && !second_phase;    // Pointer read of LDI or STI.

	// Holds the pointer after the first response and the loaded word after the last.
	always_ff @(posedge clk) begin
		if (ptr_load)
			ptr_q <= rdata;
	end

	assign mem_addr = (indirect && second_phase) ? ptr_q : ex_mem.address;

	always_comb begin
		dcache_req.read = req_on && (ptr_phase || ex_mem.cw.mem_read);
		dcache_req.write = req_on && !ptr_phase && ex_mem.cw.mem_write;
		dcache_req.address = mem_addr;
		dcache_req.byte_enable = byte_enable;
		if (ex_mem.cw.opcode == lc3b_isa_pkg::op_stb)
			dcache_req.wdata = {ex_mem.result[7:0], ex_mem.result[7:0]};
		else
			dcache_req.wdata = ex_mem.result;
	end

	assign word_in = resp ? rdata : ptr_q;

	byte_lane_logic i_byte_lane_logic (
		.addr_lsb(mem_addr[0]),
		.byte_op(ex_mem.cw.byte_op && !indirect),
		.access(req_on),
		.rdata(word_in),
		.byte_enable(byte_enable),
		.load_data(load_data)
	);

	mem_stall_logic i_mem_stall_logic (
		.clk(clk),
		.rst_n(rst_n),
		.access(access),
		.indirect(indirect),
		.resp(resp),
		.icache_stall(icache_stall),
		.second_phase(second_phase),
		.ptr_load(ptr_load),
		.mem_stall(mem_stall),
		.load_wb(fsm_load_wb)
	);

	branch_resolve i_branch_resolve (
		.valid(ex_mem.valid),
		.opcode(ex_mem.cw.opcode),
		.ir_nzp(ex_mem.ir[11:9]),
		.cc(ex_mem.cc),
		.pc_src(pc_src)
	);

	// --------------------------------------------------
	// Outputs toward writeback and the pipeline
	// --------------------------------------------------
	assign load_wb = fsm_load_wb && ex_mem.valid;
	assign mem_load_cc = ex_mem.valid && ex_mem.cw.load_cc;
	assign mem_load_regfile = ex_mem.valid && ex_mem.cw.load_regfile;
	assign mem_br_stall = ex_mem.valid && ex_mem.cw.branch_stall;

	always_comb begin
		mem_wb.valid = ex_mem.valid && !mem_stall;
		mem_wb.cw = ex_mem.cw;
		mem_wb.data = load_data;
		mem_wb.new_pc = ex_mem.new_pc;
		mem_wb.result = ex_mem.result;
		mem_wb.ir = ex_mem.ir;
		mem_wb.dr = ex_mem.dr;
	end

	// A bad control word or a phase error would drive both levels toward the cache.
	assert property (@(posedge clk) disable iff (!rst_n)
		!(dcache_req.read && dcache_req.write))
		else $error("mem_stage: read and write requested together");

endmodule : mem_stage

`default_nettype wire

//--- mem_stall_logic.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stall_logic (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic access,
	input  wire logic indirect,
	input  wire logic resp,
	input  wire logic icache_stall,
	output logic second_phase,
	output logic ptr_load,
	output logic mem_stall,
	output logic load_wb
);

	typedef enum logic [1:0] {
		st_idle,
		st_first,     // Pointer read of an indirect op.
		st_second,    // Final access.
		st_done       // Waiting for the instruction cache.
	} state_t;

	state_t state;
	state_t state_next;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= st_idle;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (access)
					state_next = indirect ? st_first : st_second;
			end
			st_first: begin
				if (resp)
					state_next = st_second;
			end
			st_second: begin
				if (resp)
					state_next = icache_stall ? st_done : st_idle;
			end
			st_done: begin
				if (!icache_stall)
					state_next = st_idle;
			end
			default: state_next = st_idle;
		endcase
	end

	// --------------------------------------------------
	// Outputs
	// --------------------------------------------------
	assign second_phase = (state == st_second);
	assign ptr_load = resp && ((state == st_first) || (state == st_second));

	// Stall drops in the cycle of the last response.
	assign mem_stall = ((state == st_idle) && access) || (state == st_first) ||
		((state == st_second) && !resp);

	assign load_wb = !icache_stall && (((state == st_idle) && !access) ||
		((state == st_second) && resp) || (state == st_done));

	// The cache only answers a request that this machine has started.
	assert property (@(posedge clk) disable iff (!rst_n) resp |-> (state != st_idle))
		else $error("mem_stall_logic: response while idle");

endmodule : mem_stall_logic

`default_nettype wire

//--- branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
	input  wire logic valid,
	input  wire lc3b_isa_pkg::lc3b_opcode opcode,
	input  wire lc3b_isa_pkg::lc3b_nzp ir_nzp,
	input  wire lc3b_isa_pkg::lc3b_nzp cc,
	output lc3b_pipe_pkg::pc_src_t pc_src
);

	always_comb begin
		pc_src = lc3b_pipe_pkg::pc_seq;
		if (valid) begin
			case (opcode)
				lc3b_isa_pkg::op_jmp,
				lc3b_isa_pkg::op_jsr:  pc_src = lc3b_pipe_pkg::pc_target;
				lc3b_isa_pkg::op_trap: pc_src = lc3b_pipe_pkg::pc_mem_data;    // Vector from memory.
				lc3b_isa_pkg::op_br: begin
					if ((cc & ir_nzp) != 3'b000)
						pc_src = lc3b_pipe_pkg::pc_target;
				end
				default: pc_src = lc3b_pipe_pkg::pc_seq;
			endcase
		end
	end

endmodule : branch_resolve

`default_nettype wire

//--- byte_lane_logic.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_params.svh"

module byte_lane_logic (
	input  wire logic addr_lsb,
	input  wire logic byte_op,
	input  wire logic access,
	input  wire lc3b_isa_pkg::lc3b_word rdata,
	output logic [1:0] byte_enable,
	output lc3b_isa_pkg::lc3b_word load_data
);

	lc3b_isa_pkg::lc3b_byte sel_byte;

	always_comb begin
		if (!access)
			byte_enable = 2'b00;
		else if (byte_op)
			byte_enable = addr_lsb ? 2'b10 : 2'b01;    // Odd address is the high lane.
		else
			byte_enable = 2'b11;
	end

	assign sel_byte = addr_lsb ? rdata[15:8] : rdata[7:0];

	// LDB sign extends the selected lane.
	assign load_data = byte_op ? {{(`LC3B_WORD_W-8){sel_byte[7]}}, sel_byte} : rdata;

endmodule : byte_lane_logic

`default_nettype wire

//--- lc3b_pipe_pkg.sv
`default_nettype none

package lc3b_pipe_pkg;

	typedef struct packed {
		lc3b_isa_pkg::lc3b_opcode opcode;
		logic mem_read;
		logic mem_write;
		logic byte_op;         // Set for LDB and STB.
		logic load_cc;
		logic load_regfile;
		logic branch_stall;
	} lc3b_control_word;

	// Execute to memory latch.
	typedef struct packed {
		logic valid;
		lc3b_control_word cw;
		lc3b_isa_pkg::lc3b_word address;
		lc3b_isa_pkg::lc3b_word new_pc;
		lc3b_isa_pkg::lc3b_word result;
		lc3b_isa_pkg::lc3b_word ir;
		lc3b_isa_pkg::lc3b_reg dr;
		lc3b_isa_pkg::lc3b_nzp cc;
	} ex_mem_latch_t;

	// Memory to writeback latch.
	typedef struct packed {
		logic valid;
		lc3b_control_word cw;
		lc3b_isa_pkg::lc3b_word data;
		lc3b_isa_pkg::lc3b_word new_pc;
		lc3b_isa_pkg::lc3b_word result;
		lc3b_isa_pkg::lc3b_word ir;
		lc3b_isa_pkg::lc3b_reg dr;
	} mem_wb_latch_t;

	typedef struct packed {
		logic read;
		logic write;
		lc3b_isa_pkg::lc3b_word address;
		lc3b_isa_pkg::lc3b_word wdata;
		logic [1:0] byte_enable;    // Bit 0 is the low byte.
	} dcache_req_t;

	typedef enum logic [1:0] {
		pc_seq      = 2'b00,
		pc_target   = 2'b01,
		pc_mem_data = 2'b10
	} pc_src_t;

endpackage : lc3b_pipe_pkg

`default_nettype wire

//--- lc3b_isa_pkg.sv
`default_nettype none

`include "lc3b_params.svh"

package lc3b_isa_pkg;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [7:0] lc3b_byte;
	typedef logic [`LC3B_REG_W-1:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;    // Negative, zero and positive flags.

	// Encodings follow bits 15 to 12 of the instruction.
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

endpackage : lc3b_isa_pkg

`default_nettype wire

//--- lc3b_params.svh
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

// --------------------------------------------------
// Data path
// --------------------------------------------------
`define LC3B_WORD_W 16
`define LC3B_REG_W 3

// --------------------------------------------------
// Data memory
// --------------------------------------------------
// Depth in words. The byte address is twice as wide in range.
`define LC3B_DMEM_WORDS 1024
`define LC3B_DCACHE_LAT 2    // Cycles from request to response.

`endif
